//--- project.f
cache_pkg.sv
mem_pkg.sv
cpu_port_if.sv
mem_bus_if.sv
dual_port_cache.sv
mem_arbiter.sv
line_memory.sv
cache_top.sv
tb_checker.sv
tb_top.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP       = tb_top
FILELIST  = project.f
OBJDIR    = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJDIR)

//--- tb_top.sv
module tb_top
    import cache_pkg::*;
    import mem_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic  fv;
        word_t faddr;
        logic  dv;
        logic  dw;
        word_t daddr;
        word_t dwdata;
    } row_t;

    row_t  rows[$];
    logic  clk;
    logic  reset_n;
    logic  fetch_valid;
    word_t fetch_addr;
    logic  fetch_ready;
    word_t fetch_rdata;
    logic  data_valid;
    logic  data_write;
    word_t data_addr;
    word_t data_wdata;
    logic  data_ready;
    word_t data_rdata;
    word_t num_hit;
    word_t num_miss;
    logic  row_end;
    logic  run_end;
    int    pass_count;
    int    fail_count;
    int    cycles;
    int    limit;

    cache_top #(
        .MEM_LATENCY (DEF_MEM_LATENCY),
        .MEM_LINES   (DEF_MEM_LINES)
    ) dut0 (.*);

    tb_checker chk0 (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic add_row(input logic fv, input word_t faddr, input logic dv,
                           input logic dw, input word_t daddr, input word_t dwdata);
        row_t r;
        r.fv     = fv;
        r.faddr  = faddr;
        r.dv     = dv;
        r.dw     = dw;
        r.daddr  = daddr;
        r.dwdata = dwdata;
        rows.push_back(r);
    endtask

    task automatic build_rows();
        logic [31:0] r;
        r = 32'hd98cd931;
        add_row(1'b0, 16'h0000, 1'b1, 1'b0, 16'h0040, 16'h0000);  // Cold miss
        add_row(1'b0, 16'h0000, 1'b1, 1'b0, 16'h0041, 16'h0000);
        add_row(1'b0, 16'h0000, 1'b1, 1'b0, 16'h0204, 16'h0000);  // Three tags in set 1
        add_row(1'b0, 16'h0000, 1'b1, 1'b0, 16'h0304, 16'h0000);
        add_row(1'b0, 16'h0000, 1'b1, 1'b0, 16'h0404, 16'h0000);
        add_row(1'b0, 16'h0000, 1'b1, 1'b0, 16'h0204, 16'h0000);
        add_row(1'b0, 16'h0000, 1'b1, 1'b1, 16'h0042, 16'h1234);  // Write hit
        add_row(1'b0, 16'h0000, 1'b1, 1'b0, 16'h0042, 16'h0000);
        add_row(1'b0, 16'h0000, 1'b1, 1'b1, 16'h0500, 16'hbeef);  // Write miss
        add_row(1'b0, 16'h0000, 1'b1, 1'b0, 16'h0500, 16'h0000);
        add_row(1'b0, 16'h0000, 1'b1, 1'b0, 16'h0600, 16'h0000);  // Evicts line 0x40
        add_row(1'b0, 16'h0000, 1'b1, 1'b0, 16'h0042, 16'h0000);  // Refetched from memory
        add_row(1'b1, 16'h0018, 1'b1, 1'b0, 16'h062c, 16'h0000);  // Both ports miss
        add_row(1'b1, 16'h0019, 1'b1, 1'b0, 16'h062d, 16'h0000);
        add_row(1'b0, 16'h0000, 1'b1, 1'b0, 16'h0728, 16'h0000);  // Fill way 1 of set 2
        add_row(1'b1, 16'h001a, 1'b1, 1'b0, 16'h072b, 16'h0000);
        // Fetch reads 0x00-0x1f, data uses 0x40-0x5f
        for (int i = 0; i < 40; i++) begin
            r = xorshift32(r);
            add_row(r[0], {11'h000, r[8:4]}, r[1] | !r[0], r[2], {11'h002, r[13:9]},
                    r[31:16]);
        end
    endtask

    task automatic run_row(input row_t r);
        logic f_pend;
        logic d_pend;
        @(negedge clk);
        fetch_valid = r.fv;
        fetch_addr  = r.faddr;
        data_valid  = r.dv;
        data_write  = r.dw;
        data_addr   = r.daddr;
        data_wdata  = r.dwdata;
        f_pend      = r.fv;
        d_pend      = r.dv;
        while (f_pend || d_pend) begin
            @(posedge clk);
            if (fetch_valid && fetch_ready) f_pend = 1'b0;
            if (data_valid && data_ready) d_pend = 1'b0;
            @(negedge clk);
            fetch_valid = f_pend;
            data_valid  = d_pend;
        end
        row_end = 1'b1;
        @(negedge clk);
        row_end = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (cycles <= limit);
        $display("Run timed out after %0d cycles", cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        reset_n     = 1'b0;
        fetch_valid = 1'b0;
        fetch_addr  = '0;
        data_valid  = 1'b0;
        data_write  = 1'b0;
        data_addr   = '0;
        data_wdata  = '0;
        row_end     = 1'b0;
        run_end     = 1'b0;
        build_rows();
        limit = rows.size() * 2 * (DEF_MEM_LATENCY + 4) + 50;
        repeat (2) @(negedge clk);
        reset_n = 1'b1;
        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        run_end = 1'b1;
        @(negedge clk);
        run_end = 1'b0;
        $display("Tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0 && pass_count == rows.size() + 1) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- tb_checker.sv
module tb_checker
    import cache_pkg::*;
(
    input  logic  clk,
    input  logic  reset_n,
    input  logic  fetch_valid,
    input  word_t fetch_addr,
    input  logic  fetch_ready,
    input  word_t fetch_rdata,
    input  logic  data_valid,
    input  logic  data_write,
    input  word_t data_addr,
    input  word_t data_wdata,
    input  logic  data_ready,
    input  word_t data_rdata,
    input  word_t num_hit,
    input  word_t num_miss,
    input  logic  row_end,
    input  logic  run_end,
    output int    pass_count,
    output int    fail_count
);
    timeunit 1ns;
    timeprecision 1ps;

    logic  m_valid [2][NUM_SETS];
    tag_t  m_tag   [2][NUM_SETS];
    logic  m_lru   [2][NUM_SETS];  // Set means least recently used
    word_t shadow  [word_t];       // Words written so far
    word_t exp_hit;
    word_t exp_miss;
    int    row_num;
    int    row_errs;
    logic  f_seen;
    logic  d_seen;
    logic  d_wr;
    addr_t f_addr_q;
    addr_t d_addr_q;

    function automatic word_t mem_word(input word_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return a ^ 16'h5a5a;  // Power-up contents
    endfunction

    // Returns {hit, way}
    function automatic logic [1:0] lookup(input addr_t a);
        logic hit0;
        logic hit1;
        hit0 = m_valid[0][a.idx] && (m_tag[0][a.idx] == a.tag);
        hit1 = m_valid[1][a.idx] && (m_tag[1][a.idx] == a.tag);
        return {hit0 || hit1, hit1};
    endfunction

    task automatic touch(input index_t s, input logic w);
        m_lru[w][s]  = 1'b0;
        m_lru[!w][s] = 1'b1;
    endtask

    task automatic fill(input addr_t a);
        logic v;
        if (m_lru[0][a.idx] == m_lru[1][a.idx]) begin
            v = 1'b0;  // Way 0 on a tie
        end else begin
            v = m_lru[1][a.idx];
        end
        m_valid[v][a.idx] = 1'b1;
        m_tag[v][a.idx]   = a.tag;
        touch(a.idx, v);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t got);
        if (exp !== got) begin
            $display("** Error: %s expected %h got %h", name, exp, got);
            row_errs++;
        end
    endtask

    // Hits finish first, then fetch fill, then data fill
    task automatic model_row();
        logic f_hit;
        logic f_way;
        logic d_hit;
        logic d_way;
        {f_hit, f_way} = lookup(f_addr_q);
        {d_hit, d_way} = lookup(d_addr_q);
        if (f_seen && f_hit) begin
            exp_hit = exp_hit + 16'd1;
            touch(f_addr_q.idx, f_way);
        end else if (f_seen) begin
            exp_miss = exp_miss + 16'd1;
        end
        if (d_seen && d_hit) begin
            exp_hit = exp_hit + 16'd1;
            if (!d_wr) begin
                touch(d_addr_q.idx, d_way);
            end
        end else if (d_seen) begin
            exp_miss = exp_miss + 16'd1;
        end
        if (f_seen && !f_hit) begin
            fill(f_addr_q);
        end
        if (d_seen && !d_hit && !d_wr) begin
            fill(d_addr_q);  // No allocate on write miss
        end
    endtask

    task automatic close_test(input string what);
        if (row_errs == 0) begin
            pass_count++;
            $display("%s ok", what);
        end else begin
            fail_count++;
            $display("%s failed with %0d mismatches", what, row_errs);
        end
        row_errs = 0;
    endtask

    always @(posedge clk) begin
        if (!reset_n) begin
            for (int w = 0; w < 2; w++) begin
                for (int s = 0; s < NUM_SETS; s++) begin
                    m_valid[w][s] = 1'b0;
                    m_lru[w][s]   = 1'b0;
                end
            end
            shadow.delete();
            exp_hit    = '0;
            exp_miss   = '0;
            row_num    = 0;
            row_errs   = 0;
            f_seen     = 1'b0;
            d_seen     = 1'b0;
            d_wr       = 1'b0;
            pass_count = 0;
            fail_count = 0;
        end else begin
            if (fetch_valid && fetch_ready) begin
                check_word("fetch_rdata", mem_word(fetch_addr), fetch_rdata);
                f_seen   = 1'b1;
                f_addr_q = addr_t'(fetch_addr);
            end
            if (data_valid && data_ready) begin
                if (data_write) begin
                    shadow[data_addr] = data_wdata;
                end else begin
                    check_word("data_rdata", mem_word(data_addr), data_rdata);
                end
                d_seen   = 1'b1;
                d_wr     = data_write;
                d_addr_q = addr_t'(data_addr);
            end
            if (row_end) begin
                model_row();
                close_test($sformatf("row %0d", row_num));
                row_num++;
                f_seen = 1'b0;
                d_seen = 1'b0;
            end
            if (run_end) begin
                check_word("num_hit", exp_hit, num_hit);
                check_word("num_miss", exp_miss, num_miss);
                close_test("counters");
            end
        end
    end

endmodule

//--- cache_top.sv
module cache_top
    import cache_pkg::*;
    import mem_pkg::*;
#(
    parameter int MEM_LATENCY = DEF_MEM_LATENCY,
    parameter int MEM_LINES   = DEF_MEM_LINES
) (
    input  logic  clk,
    input  logic  reset_n,
    input  logic  fetch_valid,
    input  word_t fetch_addr,
    output logic  fetch_ready,
    output word_t fetch_rdata,
    input  logic  data_valid,
    input  logic  data_write,
    input  word_t data_addr,
    input  word_t data_wdata,
    output logic  data_ready,
    output word_t data_rdata,
    output word_t num_hit,
    output word_t num_miss
);

    cpu_port_if fetch_if ();
    cpu_port_if data_if ();
    mem_bus_if  fetch_mem_if ();
    mem_bus_if  data_mem_if ();
    mem_bus_if  mem_if ();

    assign fetch_if.valid = fetch_valid;
    assign fetch_if.write = 1'b0;  // Fetch port is read only
    assign fetch_if.addr  = fetch_addr;
    assign fetch_if.wdata = '0;
    assign fetch_ready    = fetch_if.ready;
    assign fetch_rdata    = fetch_if.rdata;

    assign data_if.valid = data_valid;
    assign data_if.write = data_write;
    assign data_if.addr  = data_addr;
    assign data_if.wdata = data_wdata;
    assign data_ready    = data_if.ready;
    assign data_rdata    = data_if.rdata;

    dual_port_cache cache0 (
        .clk       (clk),
        .reset_n   (reset_n),
        .fetch     (fetch_if),
        .data      (data_if),
        .fetch_mem (fetch_mem_if),
        .data_mem  (data_mem_if),
        .num_hit   (num_hit),
        .num_miss  (num_miss)
    );

    mem_arbiter arb0 (
        .clk       (clk),
        .reset_n   (reset_n),
        .fetch_req (fetch_mem_if),
        .data_req  (data_mem_if),
        .mem       (mem_if)
    );

    line_memory #(
        .MEM_LATENCY (MEM_LATENCY),
        .MEM_LINES   (MEM_LINES)
    ) mem0 (
        .clk     (clk),
        .reset_n (reset_n),
        .bus     (mem_if)
    );

endmodule

//--- line_memory.sv
module line_memory
    import cache_pkg::*;
    import mem_pkg::*;
#(
    parameter int MEM_LATENCY = DEF_MEM_LATENCY,
    parameter int MEM_LINES   = DEF_MEM_LINES
) (
    input  logic     clk,
    input  logic     reset_n,
    mem_bus_if.slave bus
);

    localparam int LINE_AW = $clog2(MEM_LINES);
    localparam int CNT_W   = $clog2(MEM_LATENCY + 1);

    line_t              mem_array [MEM_LINES];
    logic               busy;
    logic [CNT_W-1:0]   count;
    logic               accept;
    mem_op_e            op_q;
    addr_t              addr_q;
    word_t              wdata_q;
    logic [LINE_AW-1:0] line_sel;

    // Each word starts as its own address scrambled
    initial begin
        for (int l = 0; l < MEM_LINES; l++) begin
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                mem_array[l][w] = word_t'(l * WORDS_PER_LINE + w) ^ 16'h5a5a;
            end
        end
    end

    assign accept   = bus.req_valid && !busy;
    assign line_sel = LINE_AW'(int'({addr_q.tag, addr_q.idx}) % MEM_LINES);  // Wraps

    assign bus.req_ready  = !busy;
    assign bus.resp_valid = busy && (count == '0);
    assign bus.resp_line  = mem_array[line_sel];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (accept) begin
            busy  <= 1'b1;
            count <= CNT_W'(MEM_LATENCY - 1);
        end else if (busy) begin
            if (count == '0) begin
                busy <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q    <= bus.req_op;
            addr_q  <= addr_t'(bus.req_addr);
            wdata_q <= bus.req_wdata;
        end
        if (bus.resp_valid && (op_q == MEM_WRITE_WORD)) begin
            mem_array[line_sel][addr_q.off] <= wdata_q;
        end
    end

endmodule

//--- mem_arbiter.sv
module mem_arbiter
    import mem_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    mem_bus_if.slave  fetch_req,
    mem_bus_if.slave  data_req,
    mem_bus_if.master mem
);

    arb_state_e state;
    logic       arb_idle;
    logic       pick_fetch;

    assign arb_idle   = (state == ARB_IDLE);
    assign pick_fetch = fetch_req.req_valid;  // Fetch fills win

    always_comb begin
        mem.req_valid = arb_idle && (fetch_req.req_valid || data_req.req_valid);
        if (pick_fetch) begin
            mem.req_op    = fetch_req.req_op;
            mem.req_addr  = fetch_req.req_addr;
            mem.req_wdata = fetch_req.req_wdata;
        end else begin
            mem.req_op    = data_req.req_op;
            mem.req_addr  = data_req.req_addr;
            mem.req_wdata = data_req.req_wdata;
        end

        fetch_req.req_ready = arb_idle && pick_fetch && mem.req_ready;
        data_req.req_ready  = arb_idle && !pick_fetch && mem.req_ready;

        // Response goes only to the owner
        fetch_req.resp_valid = (state == ARB_FETCH) && mem.resp_valid;
        data_req.resp_valid  = (state == ARB_DATA) && mem.resp_valid;
        fetch_req.resp_line  = mem.resp_line;
        data_req.resp_line   = mem.resp_line;
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= ARB_IDLE;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (mem.req_valid && mem.req_ready) begin
                        state <= pick_fetch ? ARB_FETCH : ARB_DATA;
                    end
                end
                ARB_FETCH, ARB_DATA: begin
                    if (mem.resp_valid) begin
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

endmodule

//--- dual_port_cache.sv
module dual_port_cache
    import cache_pkg::*;
    import mem_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    cpu_port_if.cache fetch,
    cpu_port_if.cache data,
    mem_bus_if.master fetch_mem,
    mem_bus_if.master data_mem,
    output word_t     num_hit,
    output word_t     num_miss
);

    logic        way_valid [2][NUM_SETS];
    tag_t        way_tag   [2][NUM_SETS];
    line_t       way_data  [2][NUM_SETS];
    logic        way_lru   [2][NUM_SETS];  // Set means least recently used

    // Per-port signals, 0 is fetch and 1 is data
    logic        p_valid    [2];
    logic        p_write    [2];
    addr_t       p_addr     [2];
    word_t       p_wdata    [2];
    logic        p_ready    [2];
    word_t       p_rdata    [2];
    logic [1:0]  p_way_hit  [2];
    logic        p_hit      [2];
    logic        p_need_mem [2];
    logic        p_issue    [2];
    logic        p_done     [2];
    logic        p_fill     [2];
    logic        p_patch    [2];
    logic        p_touch    [2];
    logic        p_way      [2];
    port_state_e p_state    [2];
    logic        p_refill   [2];
    logic        any_wait;
    logic [1:0]  hit_inc;
    logic [1:0]  miss_inc;

    logic        m_req_valid  [2];
    mem_op_e     m_req_op     [2];
    word_t       m_req_addr   [2];
    word_t       m_req_wdata  [2];
    logic        m_req_ready  [2];
    logic        m_resp_valid [2];
    line_t       m_resp_line  [2];

    assign p_valid[0]  = fetch.valid;
    assign p_write[0]  = fetch.write;
    assign p_addr[0]   = addr_t'(fetch.addr);
    assign p_wdata[0]  = fetch.wdata;
    assign fetch.ready = p_ready[0];
    assign fetch.rdata = p_rdata[0];

    assign p_valid[1] = data.valid;
    assign p_write[1] = data.write;
    assign p_addr[1]  = addr_t'(data.addr);
    assign p_wdata[1] = data.wdata;
    assign data.ready = p_ready[1];
    assign data.rdata = p_rdata[1];

    assign fetch_mem.req_valid = m_req_valid[0];
    assign fetch_mem.req_op    = m_req_op[0];
    assign fetch_mem.req_addr  = m_req_addr[0];
    assign fetch_mem.req_wdata = m_req_wdata[0];
    assign m_req_ready[0]      = fetch_mem.req_ready;
    assign m_resp_valid[0]     = fetch_mem.resp_valid;
    assign m_resp_line[0]      = fetch_mem.resp_line;

    assign data_mem.req_valid = m_req_valid[1];
    assign data_mem.req_op    = m_req_op[1];
    assign data_mem.req_addr  = m_req_addr[1];
    assign data_mem.req_wdata = m_req_wdata[1];
    assign m_req_ready[1]     = data_mem.req_ready;
    assign m_resp_valid[1]    = data_mem.resp_valid;
    assign m_resp_line[1]     = data_mem.resp_line;

    // Shared stall while either port waits on memory
    assign any_wait = (p_state[0] == PS_WAIT) || (p_state[1] == PS_WAIT);

    always_comb begin
        hit_inc  = '0;
        miss_inc = '0;
        for (int p = 0; p < 2; p++) begin
            for (int w = 0; w < 2; w++) begin
                p_way_hit[p][w] = way_valid[w][p_addr[p].idx]
                                  && (way_tag[w][p_addr[p].idx] == p_addr[p].tag);
            end
            p_hit[p]      = |p_way_hit[p];
            p_rdata[p]    = way_data[p_way_hit[p][1]][p_addr[p].idx][p_addr[p].off];
            p_need_mem[p] = p_valid[p] && (p_write[p] ? !p_refill[p] : !p_hit[p]);
            p_ready[p]    = !any_wait && !p_need_mem[p];
            p_issue[p]    = (p_state[p] == PS_IDLE) && p_need_mem[p];
            p_done[p]     = p_valid[p] && p_ready[p];
            p_fill[p]     = (p_state[p] == PS_WAIT) && m_resp_valid[p]
                            && (m_req_op[p] == MEM_READ_LINE);
            p_patch[p]    = (p_state[p] == PS_WAIT) && m_resp_valid[p]
                            && (m_req_op[p] == MEM_WRITE_WORD) && p_hit[p];
            p_touch[p]    = p_fill[p] || (p_done[p] && !p_write[p]);
            // Victim is way 1 only when it alone is LRU
            p_way[p]      = p_fill[p] ? (way_lru[1][p_addr[p].idx] && !way_lru[0][p_addr[p].idx])
                                      : p_way_hit[p][1];
            if (p_issue[p]) begin
                if (p_write[p] && p_hit[p]) begin
                    hit_inc = hit_inc + 2'd1;
                end else begin
                    miss_inc = miss_inc + 2'd1;
                end
            end else if (p_done[p] && !p_write[p] && !p_refill[p]) begin
                hit_inc = hit_inc + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int p = 0; p < 2; p++) begin
                p_state[p]     <= PS_IDLE;
                p_refill[p]    <= 1'b0;
                m_req_valid[p] <= 1'b0;
            end
            for (int w = 0; w < 2; w++) begin
                for (int s = 0; s < NUM_SETS; s++) begin
                    way_valid[w][s] <= 1'b0;
                    way_lru[w][s]   <= 1'b0;
                end
            end
            num_hit  <= '0;
            num_miss <= '0;
        end else begin
            num_hit  <= num_hit + word_t'(hit_inc);
            num_miss <= num_miss + word_t'(miss_inc);
            for (int p = 0; p < 2; p++) begin
                if (p_issue[p]) begin
                    p_state[p]     <= PS_WAIT;
                    m_req_valid[p] <= 1'b1;
                end else if (m_req_valid[p] && m_req_ready[p]) begin
                    m_req_valid[p] <= 1'b0;
                end
                if ((p_state[p] == PS_WAIT) && m_resp_valid[p]) begin
                    p_state[p]  <= PS_IDLE;
                    p_refill[p] <= 1'b1;  // Retry must not count as a hit
                end else if (p_done[p]) begin
                    p_refill[p] <= 1'b0;
                end
                if (p_fill[p]) begin
                    way_valid[p_way[p]][p_addr[p].idx] <= 1'b1;
                end
                if (p_touch[p]) begin
                    way_lru[p_way[p]][p_addr[p].idx]  <= 1'b0;
                    way_lru[!p_way[p]][p_addr[p].idx] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < 2; p++) begin
            if (p_issue[p]) begin
                m_req_op[p]    <= p_write[p] ? MEM_WRITE_WORD : MEM_READ_LINE;
                m_req_addr[p]  <= p_write[p] ? word_t'(p_addr[p])
                                             : {p_addr[p].tag, p_addr[p].idx, 2'b00};
                m_req_wdata[p] <= p_wdata[p];
            end
            if (p_fill[p]) begin
                way_tag[p_way[p]][p_addr[p].idx]  <= p_addr[p].tag;
                way_data[p_way[p]][p_addr[p].idx] <= m_resp_line[p];
            end else if (p_patch[p]) begin
                way_data[p_way[p]][p_addr[p].idx][p_addr[p].off] <= m_req_wdata[p];
            end
        end
    end

endmodule

//--- mem_bus_if.sv
interface mem_bus_if
    import cache_pkg::*;
    import mem_pkg::*;
();

    logic    req_valid;
    logic    req_ready;
    mem_op_e req_op;
    word_t   req_addr;
    word_t   req_wdata;
    logic    resp_valid;  // One pulse per accepted request
    line_t   resp_line;

    modport master (
        output req_valid,
        output req_op,
        output req_addr,
        output req_wdata,
        input  req_ready,
        input  resp_valid,
        input  resp_line
    );

    modport slave (
        input  req_valid,
        input  req_op,
        input  req_addr,
        input  req_wdata,
        output req_ready,
        output resp_valid,
        output resp_line
    );

endinterface

//--- cpu_port_if.sv
interface cpu_port_if
    import cache_pkg::*;
();

    logic  valid;
    logic  ready;
    logic  write;
    word_t addr;
    word_t wdata;
    word_t rdata;  // Valid with ready on reads

    modport cache (
        input  valid,
        input  write,
        input  addr,
        input  wdata,
        output ready,
        output rdata
    );

    modport core (
        output valid,
        output write,
        output addr,
        output wdata,
        input  ready,
        input  rdata
    );

endinterface

//--- mem_pkg.sv
package mem_pkg;

    typedef enum logic {
        MEM_READ_LINE,
        MEM_WRITE_WORD
    } mem_op_e;

    // Which cache port currently owns the memory
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_FETCH,
        ARB_DATA
    } arb_state_e;

    localparam int DEF_MEM_LATENCY = 3;     // Cycles from accept to response
    localparam int DEF_MEM_LINES   = 1024;

endpackage

//--- cache_pkg.sv
package cache_pkg;

    localparam int NUM_SETS       = 4;
    localparam int WORDS_PER_LINE = 4;

    typedef logic [15:0] word_t;
    typedef word_t [WORDS_PER_LINE-1:0] line_t;  // Word 0 in the low bits

    typedef logic [11:0] tag_t;
    typedef logic [1:0]  index_t;
    typedef logic [1:0]  offset_t;

    // Word address as tag, set and word in line
    typedef struct packed {
        tag_t    tag;
        index_t  idx;
        offset_t off;
    } addr_t;

    typedef enum logic {
        PS_IDLE,  // Nothing pending on memory
        PS_WAIT   // Fill or write ack outstanding
    } port_state_e;

endpackage
